// File: source/snn_macros.svh
`ifndef SNN_MACROS_SVH
`define SNN_MACROS_SVH

// Datapath widths
`define SNN_ADDR_W      10    // Spike source address
`define SNN_WEIGHT_W    16    // Signed synapse weight
`define SNN_POT_W       32    // Step sum and membrane potential

// Synapse table geometry
`define SNN_ENTRIES     16    // Table depth
`define SNN_PTR_W       5     // Load pointer, holds the full count

// Configuration register reset values
`define SNN_THRESH_RST  1000  // Firing threshold
`define SNN_LEAK_RST    0     // Leak per step
`define SNN_REFRACT_RST 0     // Refractory steps after a spike

`endif

// File: source/snn_pkg.sv
package snn_pkg;

    // Neuron FSM
    typedef enum logic [0:0] {
        NEU_INTEGRATE  = 1'b0,   // Accumulating steps into the membrane
        NEU_REFRACTORY = 1'b1    // Discarding steps after a spike
    } neuron_state_t;

    // Configuration register select
    typedef enum logic [1:0] {
        CFG_THRESHOLD = 2'd0,    // Firing threshold
        CFG_LEAK      = 2'd1,    // Leak subtracted per step
        CFG_REFRACT   = 2'd2     // Refractory length in steps
    } cfg_op_t;                  // Code 3 has no register

endpackage

// File: source/synapse_accumulator.sv
`timescale 1ns/1ps
`include "snn_macros.svh"

module synapse_accumulator (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            mode,         // High for load, low for run
    input  logic                            load,         // Table write strobe
    input  logic                            spike_valid,  // Incoming spike strobe
    input  logic                            time_step,    // Closes the current step
    input  logic        [`SNN_ADDR_W-1:0]   src_addr,     // Spike source or load address
    input  logic signed [`SNN_WEIGHT_W-1:0] weight_in,    // Weight for load
    output logic signed [`SNN_POT_W-1:0]    step_sum,     // Sum of the closed step
    output logic                            step_valid,   // One cycle per closed step
    output logic                            table_full    // All entries written
);

    localparam int unsigned PW = `SNN_POT_W;
    localparam int unsigned WW = `SNN_WEIGHT_W;
    localparam int unsigned IW = `SNN_PTR_W - 1;             // Table index bits

    logic        [`SNN_ADDR_W-1:0]   entry_addr   [`SNN_ENTRIES];  // Source addresses
    logic signed [`SNN_WEIGHT_W-1:0] entry_weight [`SNN_ENTRIES];  // Weights
    logic        [`SNN_ENTRIES-1:0]  entry_valid;                  // Written entries
    logic        [`SNN_PTR_W-1:0]    load_ptr;                     // Next free entry

    logic signed [`SNN_POT_W-1:0]    match_sum;   // Weights hit by this spike
    logic signed [`SNN_POT_W-1:0]    spike_add;   // Contribution taken this cycle
    logic signed [`SNN_POT_W-1:0]    run_sum;     // Open step total
    logic                            load_ok;     // Accepted load

    assign table_full = (load_ptr == `SNN_PTR_W'(`SNN_ENTRIES));  // Pointer at the end
    assign load_ok    = load && mode && !table_full;              // Load mode only

    // Parallel compare against every entry
    always_comb begin
        match_sum = '0;
        for (int i = 0; i < `SNN_ENTRIES; i++) begin
            if (entry_valid[i] && (entry_addr[i] == src_addr)) begin
                match_sum = match_sum
                          + {{(PW - WW){entry_weight[i][WW-1]}}, entry_weight[i]};  // Sign ext
            end
        end
    end

    assign spike_add = (spike_valid && !mode) ? match_sum : '0;  // Run mode spikes only

    // Table contents, no reset
    always_ff @(posedge clk) begin
        if (load_ok) begin
            entry_addr[load_ptr[IW-1:0]]   <= src_addr;
            entry_weight[load_ptr[IW-1:0]] <= weight_in;
        end
    end

    // Valid bits and load pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;                        // Table empty
            load_ptr    <= '0;
        end else if (load_ok) begin
            entry_valid[load_ptr[IW-1:0]] <= 1'b1;
            load_ptr                      <= load_ptr + 1'b1;
        end
    end

    // Running sum and step hand-off
    always_ff @(posedge clk) begin
        if (rst) begin
            run_sum    <= '0;
            step_valid <= 1'b0;
        end else begin
            step_valid <= time_step;                  // One cycle after the pulse
            if (time_step) begin
                run_sum <= '0;                        // Same-cycle spike closes with this step
            end else begin
                run_sum <= run_sum + spike_add;
            end
        end
    end

    // Closed step total, valid only with step_valid
    always_ff @(posedge clk) begin
        if (time_step) begin
            step_sum <= run_sum + spike_add;
        end
    end

endmodule

// File: source/neuron_config.sv
`timescale 1ns/1ps
`include "snn_macros.svh"

module neuron_config (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cfg_wr,       // Write strobe
    input  snn_pkg::cfg_op_t                cfg_op,       // Register select
    input  logic        [`SNN_POT_W-1:0]    cfg_data,     // Write data
    output logic signed [`SNN_POT_W-1:0]    threshold,    // Firing level
    output logic        [`SNN_WEIGHT_W-1:0] leak,         // Per step decay
    output logic        [`SNN_WEIGHT_W-1:0] refract_len   // Steps ignored after a spike
);

    import snn_pkg::*;

    localparam int unsigned PW = `SNN_POT_W;
    localparam int unsigned LW = `SNN_WEIGHT_W;

    always_ff @(posedge clk) begin
        if (rst) begin
            threshold   <= PW'(`SNN_THRESH_RST);
            leak        <= LW'(`SNN_LEAK_RST);
            refract_len <= LW'(`SNN_REFRACT_RST);
        end else if (cfg_wr) begin
            case (cfg_op)
                CFG_THRESHOLD: begin
                    threshold <= $signed(cfg_data);       // Full width, signed
                end
                CFG_LEAK: begin
                    leak <= cfg_data[LW-1:0];             // Low bits, unsigned
                end
                CFG_REFRACT: begin
                    refract_len <= cfg_data[LW-1:0];      // Low bits, unsigned
                end
                default: begin
                    threshold <= threshold;               // Unused code
                end
            endcase
        end
    end

endmodule

// File: source/lif_neuron.sv
`timescale 1ns/1ps
`include "snn_macros.svh"

module lif_neuron (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            step_valid,   // New step sum present
    input  logic signed [`SNN_POT_W-1:0]    step_sum,     // Weighted input of the step
    input  logic signed [`SNN_POT_W-1:0]    threshold,
    input  logic        [`SNN_WEIGHT_W-1:0] leak,
    input  logic        [`SNN_WEIGHT_W-1:0] refract_len,
    output logic                            spike_out,    // Fire pulse
    output logic signed [`SNN_POT_W-1:0]    membrane      // Potential, never negative
);

    import snn_pkg::*;

    localparam int unsigned PW = `SNN_POT_W;
    localparam int unsigned LW = `SNN_WEIGHT_W;
    localparam int unsigned EW = PW + 2;                 // Headroom for the update

    neuron_state_t                   state;
    logic        [`SNN_WEIGHT_W-1:0] refract_cnt;        // Steps left to discard

    logic signed [EW-1:0]            pot_raw;            // Before clamp
    logic signed [EW-1:0]            pot_clamp;          // Floored at zero
    logic signed [EW-1:0]            thresh_ext;
    logic                            fire;

    // Membrane update in extended width
    always_comb begin
        pot_raw = $signed({{2{membrane[PW-1]}}, membrane})
                - $signed({{(EW - LW){1'b0}}, leak})
                + $signed({{2{step_sum[PW-1]}}, step_sum});
        pot_clamp  = (pot_raw < 0) ? '0 : pot_raw;
        thresh_ext = $signed({{2{threshold[PW-1]}}, threshold});
        fire       = (pot_clamp >= thresh_ext);   // Above max width always fires
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= NEU_INTEGRATE;
            refract_cnt <= '0;
            membrane    <= '0;
            spike_out   <= 1'b0;
        end else begin
            spike_out <= 1'b0;                            // Pulse by default low
            if (step_valid) begin
                case (state)
                    NEU_INTEGRATE: begin
                        if (fire) begin
                            spike_out <= 1'b1;
                            membrane  <= '0;              // Reset on fire
                            if (refract_len != '0) begin
                                refract_cnt <= refract_len;
                                state       <= NEU_REFRACTORY;
                            end
                        end else begin
                            membrane <= pot_clamp[PW-1:0];
                        end
                    end
                    NEU_REFRACTORY: begin
                        membrane    <= '0;                // Input discarded
                        refract_cnt <= refract_cnt - 1'b1;
                        if (refract_cnt == LW'(1)) begin
                            state <= NEU_INTEGRATE;       // Last discarded step
                        end
                    end
                    default: begin
                        state <= NEU_INTEGRATE;
                    end
                endcase
            end
        end
    end

endmodule

// File: source/snn_neuron_top.sv
`timescale 1ns/1ps
`include "snn_macros.svh"

module snn_neuron_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            mode,         // High for load, low for run
    input  logic                            load,
    input  logic                            spike_valid,
    input  logic        [`SNN_ADDR_W-1:0]   src_addr,
    input  logic signed [`SNN_WEIGHT_W-1:0] weight_in,
    input  logic                            time_step,    // Step boundary pulse
    input  logic                            cfg_wr,
    input  snn_pkg::cfg_op_t                cfg_op,
    input  logic        [`SNN_POT_W-1:0]    cfg_data,
    output logic                            spike_out,
    output logic signed [`SNN_POT_W-1:0]    membrane,
    output logic                            table_full
);

    logic signed [`SNN_POT_W-1:0]    step_sum;      // Accumulator to neuron
    logic                            step_valid;
    logic signed [`SNN_POT_W-1:0]    threshold;     // Config to neuron
    logic        [`SNN_WEIGHT_W-1:0] leak;
    logic        [`SNN_WEIGHT_W-1:0] refract_len;

    synapse_accumulator u_acc (
        .clk         (clk),
        .rst         (rst),
        .mode        (mode),
        .load        (load),
        .spike_valid (spike_valid),
        .time_step   (time_step),
        .src_addr    (src_addr),
        .weight_in   (weight_in),
        .step_sum    (step_sum),
        .step_valid  (step_valid),
        .table_full  (table_full)
    );

    neuron_config u_cfg (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_op      (cfg_op),
        .cfg_data    (cfg_data),
        .threshold   (threshold),
        .leak        (leak),
        .refract_len (refract_len)
    );

    lif_neuron u_neuron (
        .clk         (clk),
        .rst         (rst),
        .step_valid  (step_valid),
        .step_sum    (step_sum),
        .threshold   (threshold),
        .leak        (leak),
        .refract_len (refract_len),
        .spike_out   (spike_out),
        .membrane    (membrane)
    );

endmodule

// File: bench/snn_sva.sv
`timescale 1ns/1ps
`include "snn_macros.svh"

module snn_sva (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            time_step,    // Step boundary pulse
    input  logic                            step_valid,   // Closed step strobe
    input  logic                            spike_out,    // Neuron fire pulse
    input  logic signed [`SNN_POT_W-1:0]    membrane,
    input  snn_pkg::neuron_state_t          state,        // Neuron FSM state
    input  logic        [`SNN_WEIGHT_W-1:0] refract_cnt   // Steps left in refractory
);

    import snn_pkg::*;

    // One single-cycle step_valid pulse for each time_step
    a_step_pulse: assert property (@(posedge clk) disable iff (rst)
        time_step |=> step_valid ##1 !step_valid)
        else $error("step_valid was not a one-cycle pulse after time_step");

    // Potential resets on fire
    a_spike_clears_membrane: assert property (@(posedge clk) disable iff (rst)
        spike_out |-> (membrane == '0))
        else $error("spike_out high with a nonzero membrane");

    // Refractory state always has steps left
    a_refractory_count: assert property (@(posedge clk) disable iff (rst)
        (state == NEU_REFRACTORY) |-> (refract_cnt != '0))
        else $error("refractory state with a zero counter");

endmodule

// Accumulator instance with the neuron inputs tied off
bind synapse_accumulator snn_sva u_acc_sva (
    .clk         (clk),
    .rst         (rst),
    .time_step   (time_step),
    .step_valid  (step_valid),
    .spike_out   (1'b0),
    .membrane    ({`SNN_POT_W{1'b0}}),
    .state       (snn_pkg::NEU_INTEGRATE),
    .refract_cnt ({`SNN_WEIGHT_W{1'b1}})
);

// Neuron instance with the step inputs tied low
bind lif_neuron snn_sva u_neuron_sva (
    .clk         (clk),
    .rst         (rst),
    .time_step   (1'b0),
    .step_valid  (1'b0),
    .spike_out   (spike_out),
    .membrane    (membrane),
    .state       (state),
    .refract_cnt (refract_cnt)
);

// File: bench/snn_tb.sv
`timescale 1ns/1ps
`include "snn_macros.svh"

module snn_tb;

    import snn_pkg::*;

    localparam int CLK_PERIOD  = 4;                   // ns
    localparam int RESET_CYC   = 3;
    localparam int ENTRIES     = `SNN_ENTRIES;
    localparam int RAND_STEPS  = 300;
    localparam int LOAD_CYC    = 24;                  // Upper bound per test
    localparam int ACCUM_CYC   = 20;
    localparam int LEAK_CYC    = 32;
    localparam int FIRE_CYC    = 12;
    localparam int REFRACT_CYC = 24;
    localparam int RAND_CYC    = RAND_STEPS * 10 + 2; // Up to 9 fillers plus the step
    localparam int WATCHDOG_CYC = 2 * (RESET_CYC + LOAD_CYC + ACCUM_CYC + LEAK_CYC
                                       + FIRE_CYC + REFRACT_CYC + RAND_CYC);

    logic                            clk = 1'b0;
    logic                            rst;
    logic                            mode;
    logic                            load;
    logic                            spike_valid;
    logic        [`SNN_ADDR_W-1:0]   src_addr;
    logic signed [`SNN_WEIGHT_W-1:0] weight_in;
    logic                            time_step;
    logic                            cfg_wr;
    cfg_op_t                         cfg_op;
    logic        [`SNN_POT_W-1:0]    cfg_data;
    logic                            spike_out;
    logic signed [`SNN_POT_W-1:0]    membrane;
    logic                            table_full;

    // Inputs for the next cycle, set by the tests
    logic                            n_mode;
    logic                            n_load;
    logic                            n_spike;
    logic                            n_ts;
    logic                            n_cw;
    cfg_op_t                         n_op;
    logic        [`SNN_POT_W-1:0]    n_data;
    logic        [`SNN_ADDR_W-1:0]   n_addr;
    logic signed [`SNN_WEIGHT_W-1:0] n_weight;

    // Inputs the DUT sees at the coming edge
    logic                            p_mode;
    logic                            p_load;
    logic                            p_spike;
    logic                            p_ts;
    logic                            p_cw;
    cfg_op_t                         p_op;
    logic        [`SNN_POT_W-1:0]    p_data;
    logic        [`SNN_ADDR_W-1:0]   p_addr;
    logic signed [`SNN_WEIGHT_W-1:0] p_weight;

    // Reference model state
    logic        [`SNN_ADDR_W-1:0]   m_addr   [ENTRIES];
    logic signed [`SNN_WEIGHT_W-1:0] m_weight [ENTRIES];
    int                              m_count;
    longint                          m_run;
    longint                          m_step_sum;
    logic                            m_step_valid;
    longint                          m_thresh;
    int                              m_leak;
    int                              m_refr;
    logic                            m_refractory;
    int                              m_cnt;
    longint                          m_mem;
    logic                            m_spike;

    logic [31:0]                     lfsr_state;
    string                           test_name;
    int                              test_errors;
    int                              total_errors;
    int                              tests_run;
    int                              tests_passed;

    snn_neuron_top DUT (
        .clk         (clk),
        .rst         (rst),
        .mode        (mode),
        .load        (load),
        .spike_valid (spike_valid),
        .src_addr    (src_addr),
        .weight_in   (weight_in),
        .time_step   (time_step),
        .cfg_wr      (cfg_wr),
        .cfg_op      (cfg_op),
        .cfg_data    (cfg_data),
        .spike_out   (spike_out),
        .membrane    (membrane),
        .table_full  (table_full)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR, x^32 + x^31 + x^29 + x + 1
    function automatic logic lfsr_bit();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'hD000_0001;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_bit()};        // One step per bit
        end
        return val;
    endfunction

    // Sum of loaded weights at one address
    function automatic longint match_weights(input logic [`SNN_ADDR_W-1:0] addr);
        longint sum;
        sum = 0;
        for (int i = 0; i < m_count; i++) begin
            if (m_addr[i] == addr) begin
                sum = sum + m_weight[i];
            end
        end
        return sum;
    endfunction

    // One clock edge of the model, inputs of the cycle that just ended
    task automatic model_advance();
        longint pot;
        longint contrib;
        m_spike = 1'b0;
        if (m_step_valid) begin                   // Neuron sees step and config before edge
            if (!m_refractory) begin
                pot = m_mem - m_leak + m_step_sum;
                if (pot < 0) begin
                    pot = 0;                      // Clamp at zero
                end
                if (pot >= m_thresh) begin
                    m_spike = 1'b1;
                    m_mem   = 0;
                    if (m_refr != 0) begin
                        m_cnt        = m_refr;
                        m_refractory = 1'b1;
                    end
                end else begin
                    m_mem = pot;
                end
            end else begin
                m_mem = 0;                        // Input discarded
                m_cnt = m_cnt - 1;
                if (m_cnt == 0) begin
                    m_refractory = 1'b0;
                end
            end
        end
        contrib      = (p_spike && !p_mode) ? match_weights(p_addr) : 0;
        m_step_valid = p_ts;
        if (p_ts) begin
            m_step_sum = m_run + contrib;         // Same-cycle spike closes with the step
            m_run      = 0;
        end else begin
            m_run = m_run + contrib;
        end
        if (p_load && p_mode && (m_count < ENTRIES)) begin
            m_addr[m_count]   = p_addr;
            m_weight[m_count] = p_weight;
            m_count++;
        end
        if (p_cw) begin
            case (p_op)
                CFG_THRESHOLD: m_thresh = longint'($signed(p_data));
                CFG_LEAK:      m_leak   = int'(p_data[`SNN_WEIGHT_W-1:0]);
                CFG_REFRACT:   m_refr   = int'(p_data[`SNN_WEIGHT_W-1:0]);
                default:       m_leak   = m_leak;     // Unused code
            endcase
        end
    endtask

    task automatic check_value(input string what, input longint expected, input longint actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0d actual %0d",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic compare_outputs();
        assert (!$isunknown({spike_out, membrane, table_full})) else begin
            $display("Unknown value on a DUT output during test %s", test_name);
            test_errors++;
        end
        check_value("membrane", m_mem, membrane);
        check_value("spike_out", m_spike, spike_out);
        check_value("table_full", (m_count == ENTRIES), table_full);
    endtask

    // One cycle: edge, drive, compare at the falling edge
    task automatic tick();
        @(posedge clk);
        model_advance();
        mode        <= n_mode;
        load        <= n_load;
        spike_valid <= n_spike;
        time_step   <= n_ts;
        cfg_wr      <= n_cw;
        cfg_op      <= n_op;
        cfg_data    <= n_data;
        src_addr    <= n_addr;
        weight_in   <= n_weight;
        p_mode   = n_mode;
        p_load   = n_load;
        p_spike  = n_spike;
        p_ts     = n_ts;
        p_cw     = n_cw;
        p_op     = n_op;
        p_data   = n_data;
        p_addr   = n_addr;
        p_weight = n_weight;
        n_load  = 1'b0;                           // Strobes last one cycle
        n_spike = 1'b0;
        n_ts    = 1'b0;
        n_cw    = 1'b0;
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic load_entry(input logic [`SNN_ADDR_W-1:0] addr,
                              input logic signed [`SNN_WEIGHT_W-1:0] w);
        n_load   = 1'b1;
        n_addr   = addr;
        n_weight = w;
        tick();
    endtask

    task automatic send_spike(input logic [`SNN_ADDR_W-1:0] addr);
        n_spike = 1'b1;
        n_addr  = addr;
        tick();
    endtask

    task automatic write_cfg(input cfg_op_t op, input logic [`SNN_POT_W-1:0] data);
        n_cw   = 1'b1;
        n_op   = op;
        n_data = data;
        tick();
    endtask

    // Step pulse, then wait until the membrane shows it
    task automatic end_step(input logic with_spike, input logic [`SNN_ADDR_W-1:0] addr);
        n_ts    = 1'b1;
        n_spike = with_spike;
        n_addr  = addr;
        tick();
        tick();
        tick();
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %s: ok", test_name);
        end else begin
            $display("Test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic run_loading();
        logic signed [`SNN_WEIGHT_W-1:0] w;
        begin_test("loading");
        n_mode = 1'b0;
        load_entry(10'd200, 16'sd1234);           // Run mode, ignored
        load_entry(10'd201, -16'sd99);
        n_mode = 1'b1;
        for (int i = 0; i < 18; i++) begin
            w = (i % 3 == 2) ? 16'(-(i * 40)) : 16'(i * 100 + 7);
            if (i >= ENTRIES) begin
                w = 16'sd5000;                    // Extra loads, must not land
            end
            load_entry(10'(100 + i % 6), w);
            if (i == 15) begin
                check_value("table_full with the 16th load", 0, table_full);
            end
            if (i == 16) begin
                check_value("table_full after the 16th load", 1, table_full);
            end
        end
        n_mode = 1'b0;
        tick();
        end_test();
    endtask

    task automatic run_accumulation();
        begin_test("accumulation");
        write_cfg(CFG_THRESHOLD, 32'd1_000_000);  // Out of reach
        send_spike(10'd100);                      // Three entries at 100
        send_spike(10'd101);
        send_spike(10'd100);
        send_spike(10'd105);                      // Negative weights
        send_spike(10'd200);                      // No match
        end_step(1'b1, 10'd103);                  // Spike on the step edge
        check_value("membrane after step", 7844, membrane);
        n_mode = 1'b1;
        send_spike(10'd100);                      // Load mode, ignored
        send_spike(10'd103);
        n_mode = 1'b0;
        end_step(1'b0, '0);
        check_value("membrane after load mode spikes", 7844, membrane);
        end_test();
    endtask

    task automatic run_leak();
        begin_test("leak and clamp");
        write_cfg(CFG_LEAK, 32'd2000);
        for (int i = 0; i < 6; i++) begin
            end_step(1'b0, '0);                   // Empty steps
        end
        check_value("membrane after leak", 0, membrane);
        write_cfg(CFG_LEAK, 32'd0);
        send_spike(10'd100);
        end_step(1'b0, '0);
        send_spike(10'd102);                      // Two negative hits
        send_spike(10'd102);
        end_step(1'b0, '0);
        check_value("membrane after negative step", 0, membrane);
        end_test();
    endtask

    task automatic run_firing();
        begin_test("firing");
        write_cfg(CFG_THRESHOLD, 32'd3000);
        send_spike(10'd101);
        end_step(1'b0, '0);
        check_value("spike_out below threshold", 0, spike_out);
        send_spike(10'd100);                      // Crosses 3000
        n_ts = 1'b1;
        tick();
        check_value("spike_out on the step cycle", 0, spike_out);
        tick();
        check_value("spike_out one cycle after step", 0, spike_out);
        tick();
        check_value("spike_out two cycles after step", 1, spike_out);
        check_value("membrane on spike", 0, membrane);
        tick();
        check_value("spike_out pulse width", 0, spike_out);
        end_test();
    endtask

    task automatic run_refractory();
        begin_test("refractory");
        write_cfg(CFG_REFRACT, 32'd3);
        send_spike(10'd100);
        end_step(1'b1, 10'd101);
        check_value("spike_out on fire", 1, spike_out);
        for (int i = 0; i < 3; i++) begin
            send_spike(10'd103);
            end_step(1'b0, '0);
            check_value("membrane while refractory", 0, membrane);
        end
        send_spike(10'd103);
        end_step(1'b0, '0);
        check_value("membrane after refractory", 2721, membrane);  // 307 + 907 + 1507
        end_test();
    endtask

    // Random traffic for one cycle
    task automatic random_inputs();
        logic [1:0] op_code;
        if (n_mode) begin
            n_mode = rand_bits(1) ? 1'b0 : 1'b1;  // Short load phases
        end else if (rand_bits(5) == 0) begin
            n_mode = 1'b1;
        end
        n_spike  = rand_bits(1);
        n_addr   = rand_bits(1) ? 10'(100 + rand_bits(3) % 6) : 10'(rand_bits(10));
        n_weight = 16'(rand_bits(16));
        n_load   = (rand_bits(3) == 0);
        if (rand_bits(4) == 0) begin
            op_code = 2'(rand_bits(2));
            n_cw    = 1'b1;
            n_op    = cfg_op_t'(op_code);
            case (op_code)
                2'd0:    n_data = 32'(rand_bits(13)) + 32'd500;
                2'd1:    n_data = 32'(rand_bits(9));
                2'd2:    n_data = 32'(rand_bits(2));
                default: n_data = rand_bits(32);  // No register
            endcase
        end
    endtask

    task automatic run_random();
        int gap;
        begin_test("random run");
        for (int s = 0; s < RAND_STEPS; s++) begin
            gap = 2 + int'(rand_bits(3));         // Keeps steps 3 or more apart
            for (int c = 0; c < gap; c++) begin
                random_inputs();
                tick();
            end
            random_inputs();
            n_ts = 1'b1;
            tick();
        end
        tick();
        tick();
        end_test();
    endtask

    initial begin
        rst          = 1'b1;
        mode         = 1'b0;
        load         = 1'b0;
        spike_valid  = 1'b0;
        time_step    = 1'b0;
        cfg_wr       = 1'b0;
        cfg_op       = CFG_THRESHOLD;
        cfg_data     = '0;
        src_addr     = '0;
        weight_in    = '0;
        n_mode       = 1'b0;
        n_load       = 1'b0;
        n_spike      = 1'b0;
        n_ts         = 1'b0;
        n_cw         = 1'b0;
        n_op         = CFG_THRESHOLD;
        n_data       = '0;
        n_addr       = '0;
        n_weight     = '0;
        p_mode       = 1'b0;
        p_load       = 1'b0;
        p_spike      = 1'b0;
        p_ts         = 1'b0;
        p_cw         = 1'b0;
        p_op         = CFG_THRESHOLD;
        p_data       = '0;
        p_addr       = '0;
        p_weight     = '0;
        m_count      = 0;                         // Model after reset
        m_run        = 0;
        m_step_sum   = 0;
        m_step_valid = 1'b0;
        m_thresh     = `SNN_THRESH_RST;
        m_leak       = `SNN_LEAK_RST;
        m_refr       = `SNN_REFRACT_RST;
        m_refractory = 1'b0;
        m_cnt        = 0;
        m_mem        = 0;
        m_spike      = 1'b0;
        lfsr_state   = 32'd22;
        total_errors = 0;
        tests_run    = 0;
        tests_passed = 0;
        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b0;
        run_loading();
        run_accumulation();
        run_leak();
        run_firing();
        run_refractory();
        run_random();
        $display("Tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, total_errors);
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog, twice the summed test lengths
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: build.f
+incdir+source
source/snn_pkg.sv
source/synapse_accumulator.sv
source/neuron_config.sv
source/lif_neuron.sv
source/snn_neuron_top.sv
bench/snn_sva.sv
bench/snn_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module snn_tb -f build.f \
    && ./obj_dir/Vsnn_tb > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$LOG"

grep -qF "** FAIL **" "$LOG" \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
